//--- rtl/loader_pkg.sv
package loader_pkg;

	// ==================================================
	// Memory address space
	// ==================================================
	localparam int ADDR_W = 25;
	typedef logic [ADDR_W-1:0] mem_addr_t;

	// Kind of file being downloaded
	typedef enum logic [1:0] {
		KIND_NONE, KIND_PRG, KIND_CRT, KIND_TAP
	} file_kind_e;

	// One host byte after classification
	typedef struct packed {
		logic              valid;
		file_kind_e        kind;
		logic [ADDR_W-1:0] offset;
		logic [7:0]        data;
	} dl_byte_t;

	// One byte write into shared memory
	typedef struct packed {
		logic       valid;
		mem_addr_t  addr;
		logic [7:0] data;
	} mem_wr_t;

	// Chip packet record
	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] size;
	} cart_bank_t;

	// Cartridge header fields
	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_t;

	// ==================================================
	// Host index codes
	// ==================================================
	// Program index, top two index bits must be zero
	localparam logic [5:0] IDX_PRG_LOW = 6'd4;
	localparam logic [7:0] IDX_CRT_A   = 8'h05;
	localparam logic [7:0] IDX_CRT_B   = 8'hC0;
	localparam logic [7:0] IDX_TAP     = 8'h06;

	// First chip packet offset and packet header length
	localparam logic [7:0] CRT_DATA_START = 8'h40;
	localparam int         CRT_PKT_HDR    = 16;

endpackage

//--- rtl/stream_decoder.sv
`timescale 1ns/1ps

module stream_decoder (
	input  logic                            clk_sys,
	input  logic                            reset_n,
	input  logic                            dl_active_i,
	input  logic [7:0]                      dl_index_i,
	input  logic                            dl_wr_i,
	input  logic [loader_pkg::ADDR_W-1:0]   dl_addr_i,
	input  logic [7:0]                      dl_data_i,
	output loader_pkg::dl_byte_t            byte_o,
	output logic                            prg_done_o
);
	import loader_pkg::*;

	file_kind_e kind;
	file_kind_e kind_q;
	logic       active_q;

	// Map host index to file kind
	always_comb begin
		if (dl_index_i[7:6] == 2'b00 && dl_index_i[5:0] == IDX_PRG_LOW) begin
			kind = KIND_PRG;
		end else if (dl_index_i == IDX_CRT_A || dl_index_i == IDX_CRT_B) begin
			kind = KIND_CRT;
		end else if (dl_index_i == IDX_TAP) begin
			kind = KIND_TAP;
		end else begin
			kind = KIND_NONE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			byte_o.valid <= 1'b0;
			active_q     <= 1'b0;
			kind_q       <= KIND_NONE;
			prg_done_o   <= 1'b0;
		end else begin
			byte_o.valid  <= dl_wr_i;
			byte_o.kind   <= kind;
			byte_o.offset <= dl_addr_i;
			byte_o.data   <= dl_data_i;
			active_q      <= dl_active_i;
			// Remember the kind of the running download for its end
			if (dl_active_i) begin
				kind_q <= kind;
			end
			prg_done_o <= active_q && !dl_active_i && (kind_q == KIND_PRG);
		end
	end

	// Host only strobes bytes inside a download
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!reset_n)
		dl_wr_i |-> dl_active_i)
		else $error("dl_wr_i outside of a download");

endmodule

//--- rtl/prg_tap_addresser.sv
`timescale 1ns/1ps

module prg_tap_addresser #(
	parameter loader_pkg::mem_addr_t TAP_BASE = 25'h200000
) (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  loader_pkg::dl_byte_t  byte_i,
	output loader_pkg::mem_wr_t   wr_o,
	output loader_pkg::mem_addr_t prg_end_o
);
	import loader_pkg::*;

	logic [15:0] prg_addr;
	logic        is_prg;
	logic        is_tap;

	assign is_prg = byte_i.valid && (byte_i.kind == KIND_PRG);
	assign is_tap = byte_i.valid && (byte_i.kind == KIND_TAP);

	// Next free address, so after the last byte it is the end address
	assign prg_end_o = mem_addr_t'(prg_addr);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_o.valid <= 1'b0;
			prg_addr   <= '0;
		end else begin
			wr_o.valid <= 1'b0;
			wr_o.data  <= byte_i.data;
			if (is_prg) begin
				// First two bytes carry the load address, little-endian
				if (byte_i.offset == 'd0) begin
					prg_addr[7:0] <= byte_i.data;
				end else if (byte_i.offset == 'd1) begin
					prg_addr[15:8] <= byte_i.data;
				end else begin
					wr_o.valid <= 1'b1;
					wr_o.addr  <= mem_addr_t'(prg_addr);
					prg_addr   <= prg_addr + 16'd1;
				end
			end
			if (is_tap) begin
				// Tape image is stored verbatim
				wr_o.valid <= 1'b1;
				wr_o.addr  <= TAP_BASE + byte_i.offset;
			end
		end
	end

endmodule

//--- rtl/crt_parser.sv
`timescale 1ns/1ps

module crt_parser #(
	parameter loader_pkg::mem_addr_t CRT_BASE = 25'h100000
) (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  loader_pkg::dl_byte_t   byte_i,
	output loader_pkg::mem_wr_t    wr_o,
	output loader_pkg::cart_info_t cart_info_o,
	output loader_pkg::cart_bank_t cart_bank_o,
	output logic                   cart_bank_wr_o
);
	import loader_pkg::*;

	localparam logic [4:0] HDR_LAST = 5'(CRT_PKT_HDR - 1);

	mem_addr_t   crt_addr;
	logic [4:0]  hdr_cnt;
	logic [31:0] blk_len;
	logic        is_crt;

	assign is_crt = byte_i.valid && (byte_i.kind == KIND_CRT);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_o.valid     <= 1'b0;
			cart_bank_wr_o <= 1'b0;
			cart_info_o    <= '0;
			crt_addr       <= CRT_BASE;
			hdr_cnt        <= '0;
			blk_len        <= '0;
		end else begin
			wr_o.valid     <= 1'b0;
			cart_bank_wr_o <= 1'b0;
			if (is_crt) begin
				wr_o.data <= byte_i.data;

				// Start of a new image
				if (byte_i.offset == '0) begin
					crt_addr <= CRT_BASE;
					hdr_cnt  <= '0;
					blk_len  <= '0;
				end

				// File header fields, id is big-endian
				case (byte_i.offset)
					'h16: cart_info_o.id[15:8] <= byte_i.data;
					'h17: cart_info_o.id[7:0]  <= byte_i.data;
					'h18: cart_info_o.exrom    <= byte_i.data;
					'h19: cart_info_o.game     <= byte_i.data;
					default: ;
				endcase

				// ==================================================
				// Chip packets
				// ==================================================
				if (byte_i.offset >= CRT_DATA_START) begin
					if (hdr_cnt == '0 && blk_len == '0) begin
						// First byte of a packet, data goes to the next 8 KB bank
						hdr_cnt <= 5'd1;
						if (crt_addr[12:0] != '0) begin
							crt_addr <= {crt_addr[ADDR_W-1:13] + 1'b1, 13'd0};
						end
					end else if (hdr_cnt != '0) begin
						hdr_cnt <= (hdr_cnt == HDR_LAST) ? 5'd0 : hdr_cnt + 5'd1;
						case (hdr_cnt)
							5'd4: blk_len[31:24] <= byte_i.data;
							5'd5: blk_len[23:16] <= byte_i.data;
							5'd6: blk_len[15:8]  <= byte_i.data;
							5'd7: blk_len[7:0]   <= byte_i.data;
							// Packet length includes its own header
							5'd8: blk_len <= blk_len - CRT_PKT_HDR;
							5'd9: cart_bank_o.bank_type <= byte_i.data;
							5'd10: cart_bank_o.bank_num[15:8]  <= byte_i.data;
							5'd11: cart_bank_o.bank_num[7:0]   <= byte_i.data;
							5'd12: cart_bank_o.load_addr[15:8] <= byte_i.data;
							5'd13: cart_bank_o.load_addr[7:0]  <= byte_i.data;
							5'd14: cart_bank_o.size[15:8]      <= byte_i.data;
							HDR_LAST: begin
								cart_bank_o.size[7:0] <= byte_i.data;
								cart_bank_wr_o        <= 1'b1;
							end
							default: ;
						endcase
					end else begin
						// Packet payload
						wr_o.valid <= 1'b1;
						wr_o.addr  <= crt_addr;
						crt_addr   <= crt_addr + 1'b1;
						blk_len    <= blk_len - 32'd1;
					end
				end
			end
		end
	end

	// Header counter wraps to zero after the last header byte
	a_hdr_cnt_range: assert property (@(posedge clk_sys) disable iff (!reset_n)
		hdr_cnt <= HDR_LAST)
		else $error("chip packet header count out of range");

endmodule

//--- rtl/basic_ptr_init.sv
`timescale 1ns/1ps

module basic_ptr_init (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  start_i,
	input  loader_pkg::mem_addr_t prg_end_i,
	input  logic                  taken_i,
	output loader_pkg::mem_wr_t   wr_o,
	output logic                  busy_o
);
	import loader_pkg::*;

	localparam logic [3:0] LAST_IDX = 4'd13;

	logic [3:0]  idx;
	logic [15:0] end_q;
	logic [7:0]  ptr_addr;
	logic [7:0]  ptr_val;

	// Zero page pointers as BASIC leaves them after LOAD
	always_comb begin
		case (idx)
			4'd0:    begin ptr_addr = 8'h2B; ptr_val = 8'h01;        end
			4'd1:    begin ptr_addr = 8'h2C; ptr_val = 8'h08;        end
			4'd2:    begin ptr_addr = 8'hAC; ptr_val = 8'h00;        end
			4'd3:    begin ptr_addr = 8'hAD; ptr_val = 8'h00;        end
			// VARTAB, ARYTAB, STREND and load end all point past the program
			4'd4:    begin ptr_addr = 8'h2D; ptr_val = end_q[7:0];  end
			4'd5:    begin ptr_addr = 8'h2E; ptr_val = end_q[15:8]; end
			4'd6:    begin ptr_addr = 8'h2F; ptr_val = end_q[7:0];  end
			4'd7:    begin ptr_addr = 8'h30; ptr_val = end_q[15:8]; end
			4'd8:    begin ptr_addr = 8'h31; ptr_val = end_q[7:0];  end
			4'd9:    begin ptr_addr = 8'h32; ptr_val = end_q[15:8]; end
			4'd10:   begin ptr_addr = 8'hAE; ptr_val = end_q[7:0];  end
			4'd11:   begin ptr_addr = 8'hAF; ptr_val = end_q[15:8]; end
			// String top back at top of BASIC memory
			4'd12:   begin ptr_addr = 8'h33; ptr_val = 8'h00;        end
			4'd13:   begin ptr_addr = 8'h34; ptr_val = 8'hA0;        end
			default: begin ptr_addr = 8'h00; ptr_val = 8'h00;        end
		endcase
	end

	always_comb begin
		wr_o.valid = busy_o;
		wr_o.addr  = mem_addr_t'(ptr_addr);
		wr_o.data  = ptr_val;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			busy_o <= 1'b0;
			idx    <= '0;
		end else if (start_i) begin
			busy_o <= 1'b1;
			idx    <= '0;
			end_q  <= prg_end_i[15:0];
		end else if (busy_o && taken_i) begin
			if (idx == LAST_IDX) begin
				busy_o <= 1'b0;
			end else begin
				idx <= idx + 4'd1;
			end
		end
	end

endmodule

//--- rtl/slot_writer.sv
`timescale 1ns/1ps

module slot_writer (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  loader_pkg::mem_wr_t   prg_wr_i,
	input  loader_pkg::mem_wr_t   crt_wr_i,
	input  loader_pkg::mem_wr_t   ptr_wr_i,
	input  logic                  ptr_busy_i,
	input  logic                  stage_busy_i,
	input  logic                  mem_slot_i,
	output logic                  ptr_taken_o,
	output logic                  ioctl_wait_o,
	output logic                  mem_we_o,
	output loader_pkg::mem_addr_t mem_addr_o,
	output logic [7:0]            mem_data_o
);
	import loader_pkg::*;

	mem_wr_t held;
	mem_wr_t stream_wr;
	logic    stream_in;
	logic    inflight_q;

	assign stream_in = prg_wr_i.valid || crt_wr_i.valid;
	assign stream_wr = prg_wr_i.valid ? prg_wr_i : crt_wr_i;

	// Pointer writes only fill an idle pipeline
	assign ptr_taken_o = ptr_wr_i.valid && !held.valid && !stream_in &&
		!inflight_q && !stage_busy_i;

	// Host is held off while anything is between the host and memory
	assign ioctl_wait_o = stage_busy_i || inflight_q || held.valid || ptr_busy_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			held.valid <= 1'b0;
			inflight_q <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			// Byte sits in stage 2 the cycle after stage 1
			inflight_q <= stage_busy_i;
			mem_we_o   <= mem_slot_i && held.valid;
			if (mem_slot_i && held.valid) begin
				mem_addr_o <= held.addr;
				mem_data_o <= held.data;
				held.valid <= 1'b0;
			end
			if (stream_in) begin
				held <= stream_wr;
			end else if (ptr_taken_o) begin
				held <= ptr_wr_i;
			end
		end
	end

	// ==================================================
	// Pipeline occupancy checks
	// ==================================================
	a_one_stream: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(prg_wr_i.valid && crt_wr_i.valid))
		else $error("program and cartridge writes collide");

	a_no_overrun: assert property (@(posedge clk_sys) disable iff (!reset_n)
		stream_in |-> !held.valid)
		else $error("stream write arrived while a write is held");

endmodule

//--- rtl/c64_loader_top.sv
`timescale 1ns/1ps

module c64_loader_top #(
	parameter loader_pkg::mem_addr_t CRT_BASE = 25'h100000,
	parameter loader_pkg::mem_addr_t TAP_BASE = 25'h200000
) (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	input  logic                          dl_active_i,
	input  logic [7:0]                    dl_index_i,
	input  logic                          dl_wr_i,
	input  logic [loader_pkg::ADDR_W-1:0] dl_addr_i,
	input  logic [7:0]                    dl_data_i,
	input  logic                          mem_slot_i,
	output logic                          ioctl_wait_o,
	output logic                          mem_we_o,
	output loader_pkg::mem_addr_t         mem_addr_o,
	output logic [7:0]                    mem_data_o,
	output loader_pkg::cart_info_t        cart_info_o,
	output loader_pkg::cart_bank_t        cart_bank_o,
	output logic                          cart_bank_wr_o
);
	import loader_pkg::*;

	dl_byte_t  dl_byte;
	logic      prg_done;
	mem_wr_t   prg_wr;
	mem_wr_t   crt_wr;
	mem_wr_t   ptr_wr;
	mem_addr_t prg_end;
	logic      ptr_busy;
	logic      ptr_taken;

	// Stage 1
	stream_decoder u_decoder (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.byte_o      (dl_byte),
		.prg_done_o  (prg_done)
	);

	// Stage 2
	prg_tap_addresser #(.TAP_BASE(TAP_BASE)) u_prg_tap (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.byte_i    (dl_byte),
		.wr_o      (prg_wr),
		.prg_end_o (prg_end)
	);

	crt_parser #(.CRT_BASE(CRT_BASE)) u_crt (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.byte_i         (dl_byte),
		.wr_o           (crt_wr),
		.cart_info_o    (cart_info_o),
		.cart_bank_o    (cart_bank_o),
		.cart_bank_wr_o (cart_bank_wr_o)
	);

	basic_ptr_init u_ptr (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.start_i   (prg_done),
		.prg_end_i (prg_end),
		.taken_i   (ptr_taken),
		.wr_o      (ptr_wr),
		.busy_o    (ptr_busy)
	);

	// Stage 3
	slot_writer u_writer (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.prg_wr_i     (prg_wr),
		.crt_wr_i     (crt_wr),
		.ptr_wr_i     (ptr_wr),
		.ptr_busy_i   (ptr_busy),
		.stage_busy_i (dl_byte.valid),
		.mem_slot_i   (mem_slot_i),
		.ptr_taken_o  (ptr_taken),
		.ioctl_wait_o (ioctl_wait_o),
		.mem_we_o     (mem_we_o),
		.mem_addr_o   (mem_addr_o),
		.mem_data_o   (mem_data_o)
	);

endmodule

//--- sim/tb_c64_loader.sv
`timescale 1ns/1ps

module tb_c64_loader;
	import loader_pkg::*;

	localparam mem_addr_t   CRT_BASE   = 25'h100000;
	localparam mem_addr_t   TAP_BASE   = 25'h200000;
	localparam int          EXP_DEPTH  = 256;
	localparam int          WAIT_LIMIT = 2000;
	localparam logic [31:0] RAND_SEED  = 32'h8369_2146;

	logic             clk_sys = 1'b0;
	logic             reset_n;
	logic             dl_active_i;
	logic [7:0]       dl_index_i;
	logic             dl_wr_i;
	logic [ADDR_W-1:0] dl_addr_i;
	logic [7:0]       dl_data_i;
	logic             mem_slot_i = 1'b0;
	logic             ioctl_wait_o;
	logic             mem_we_o;
	mem_addr_t        mem_addr_o;
	logic [7:0]       mem_data_o;
	cart_info_t       cart_info_o;
	cart_bank_t       cart_bank_o;
	logic             cart_bank_wr_o;

	// Expected write queue consumed on each mem_we_o
	mem_addr_t  exp_addr [EXP_DEPTH];
	logic [7:0] exp_data [EXP_DEPTH];
	int         exp_count;
	int         rd_idx;
	logic       head_valid;
	mem_addr_t  head_addr;
	logic [7:0] head_data;

	cart_bank_t exp_bank;
	int         bank_count;
	int         slot_gap = 0;
	logic       slow_slots = 1'b0;
	logic       idle_chk = 1'b0;
	logic       wait_chk = 1'b0;
	logic       timed_out;
	string      cur_test;
	int         errors;
	int         err_mark;
	int         tests_run;
	int         tests_failed;

	c64_loader_top #(
		.CRT_BASE (CRT_BASE),
		.TAP_BASE (TAP_BASE)
	) DUT (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_wr_i        (dl_wr_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.mem_slot_i     (mem_slot_i),
		.ioctl_wait_o   (ioctl_wait_o),
		.mem_we_o       (mem_we_o),
		.mem_addr_o     (mem_addr_o),
		.mem_data_o     (mem_data_o),
		.cart_info_o    (cart_info_o),
		.cart_bank_o    (cart_bank_o),
		.cart_bank_wr_o (cart_bank_wr_o)
	);

	always #10 clk_sys = ~clk_sys;

	// Free memory slots at random gaps with longer ones in slow mode
	always @(posedge clk_sys) begin
		if (slot_gap == 0) begin
			mem_slot_i <= 1'b1;
			slot_gap   <= slow_slots ? 8 + int'($urandom % 8) : 1 + int'($urandom % 6);
		end else begin
			mem_slot_i <= 1'b0;
			slot_gap   <= slot_gap - 1;
		end
	end

	assign head_valid = rd_idx < exp_count;
	assign head_addr  = exp_addr[rd_idx[7:0]];
	assign head_data  = exp_data[rd_idx[7:0]];

	always @(posedge clk_sys) begin
		if (!reset_n) begin
			rd_idx     <= 0;
			bank_count <= 0;
		end else begin
			if (mem_we_o) begin
				rd_idx <= rd_idx + 1;
			end
			if (cart_bank_wr_o) begin
				bank_count <= bank_count + 1;
			end
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	a_write_expected: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |-> head_valid)
		else begin
			$display("%s: memory write to %h when none was expected", cur_test,
				$sampled(mem_addr_o));
			errors++;
		end

	a_write_value: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(mem_we_o && head_valid) |-> (mem_addr_o == head_addr && mem_data_o == head_data))
		else begin
			$display("ERROR %s: expected %h <= %h, actual %h <= %h", cur_test,
				$sampled(head_addr), $sampled(head_data),
				$sampled(mem_addr_o), $sampled(mem_data_o));
			errors++;
		end

	a_bank_value: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cart_bank_wr_o |-> (cart_bank_o == exp_bank))
		else begin
			$display("ERROR %s: expected bank %h, actual %h", cur_test,
				$sampled(exp_bank), $sampled(cart_bank_o));
			errors++;
		end

	a_idle_quiet: assert property (@(posedge clk_sys) disable iff (!reset_n)
		idle_chk |-> (!mem_we_o && !ioctl_wait_o && !cart_bank_wr_o))
		else begin
			$display("%s: an output went high with no download running", cur_test);
			errors++;
		end

	// Host must be held off until the pending byte reaches memory
	a_wait_held: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(wait_chk && head_valid && !mem_we_o) |-> ioctl_wait_o)
		else begin
			$display("%s: ioctl_wait_o low while a write is pending", cur_test);
			errors++;
		end

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected) else begin
			$display("ERROR %s: %s expected %h, actual %h", cur_test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic expect_write(input mem_addr_t addr, input logic [7:0] data);
		exp_addr[exp_count[7:0]] = addr;
		exp_data[exp_count[7:0]] = data;
		exp_count++;
	endtask

	task automatic wait_ready();
		int n;
		if (timed_out) return;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while (ioctl_wait_o && n < WAIT_LIMIT);
		if (ioctl_wait_o) begin
			timed_out = 1'b1;
			$display("Timeout: ioctl_wait_o stayed high in %s", cur_test);
		end
	endtask

	task automatic drain_writes();
		int n;
		if (timed_out) return;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while ((rd_idx != exp_count || ioctl_wait_o) && n < WAIT_LIMIT);
		if (rd_idx != exp_count || ioctl_wait_o) begin
			timed_out = 1'b1;
			$display("Timeout: %0d expected writes never arrived in %s",
				exp_count - rd_idx, cur_test);
		end
	endtask

	// ==================================================
	// Host side
	// ==================================================
	task automatic begin_download(input logic [7:0] index);
		if (timed_out) return;
		@(posedge clk_sys);
		dl_index_i  <= index;
		dl_active_i <= 1'b1;
	endtask

	task automatic end_download();
		wait_ready();
		if (timed_out) return;
		dl_active_i <= 1'b0;
	endtask

	// One byte on the host strobe with its expected write queued once in flight
	task automatic send_byte(input int offset, input logic [7:0] data,
		input logic has_write, input mem_addr_t addr);
		wait_ready();
		if (timed_out) return;
		dl_wr_i   <= 1'b1;
		dl_addr_i <= offset[ADDR_W-1:0];
		dl_data_i <= data;
		@(posedge clk_sys);
		dl_wr_i <= 1'b0;
		@(posedge clk_sys);
		if (has_write) begin
			expect_write(addr, data);
		end
	endtask

	function automatic logic [7:0] crt_header_byte(input int offset);
		string sig;
		sig = "C64 CARTRIDGE   ";
		case (offset)
			'h13: return 8'h40;
			'h14: return 8'h01;
			'h17: return 8'h20;
			'h18: return 8'h01;
			default: return (offset < 16) ? sig[offset] : 8'h00;
		endcase
	endfunction

	// ROM chip packet with 32 data bytes loaded at 8000h
	task automatic send_packet(input int start, input logic [15:0] bank, input mem_addr_t dest);
		logic [7:0] hdr [16];
		logic [7:0] b;
		int         k;
		hdr = '{8'h43, 8'h48, 8'h49, 8'h50, 8'h00, 8'h00, 8'h00, 8'h30,
			8'h00, 8'h00, bank[15:8], bank[7:0], 8'h80, 8'h00, 8'h00, 8'h20};
		exp_bank = {8'h00, bank, 16'h8000, 16'h0020};
		for (k = 0; k < 16; k++) begin
			send_byte(start + k, hdr[k], 1'b0, '0);
		end
		for (k = 0; k < 32; k++) begin
			b = 8'($urandom);
			send_byte(start + 16 + k, b, 1'b1, dest + mem_addr_t'(k));
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_mark = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors != err_mark || timed_out) begin
			tests_failed++;
			$display("%-20s fail", cur_test);
		end else begin
			$display("%-20s pass", cur_test);
		end
	endtask

	initial begin
		logic [7:0]  b;
		int          i;
		void'($urandom(RAND_SEED));
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i  = 8'h00;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = 8'h00;
		exp_bank    = '0;
		exp_count   = 0;
		timed_out   = 1'b0;
		errors      = 0;
		tests_run   = 0;
		tests_failed = 0;
		cur_test    = "reset";
		repeat (8) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(posedge clk_sys);

		start_test("after reset");
		check_value("cart_info_o", 32'h0, cart_info_o);
		idle_chk = 1'b1;
		repeat (50) @(posedge clk_sys);
		idle_chk = 1'b0;
		finish_test();

		// Load address 0801h sent low byte first
		start_test("program data");
		begin_download(8'h04);
		send_byte(0, 8'h01, 1'b0, '0);
		send_byte(1, 8'h08, 1'b0, '0);
		for (i = 0; i < 20; i++) begin
			b = 8'($urandom);
			send_byte(i + 2, b, 1'b1, mem_addr_t'(25'h0801 + i));
		end
		drain_writes();
		finish_test();

		// Zero page pointers after LOAD with end address 0815h
		start_test("basic pointers");
		end_download();
		expect_write(25'h2B, 8'h01);
		expect_write(25'h2C, 8'h08);
		expect_write(25'hAC, 8'h00);
		expect_write(25'hAD, 8'h00);
		expect_write(25'h2D, 8'h15);
		expect_write(25'h2E, 8'h08);
		expect_write(25'h2F, 8'h15);
		expect_write(25'h30, 8'h08);
		expect_write(25'h31, 8'h15);
		expect_write(25'h32, 8'h08);
		expect_write(25'hAE, 8'h15);
		expect_write(25'hAF, 8'h08);
		expect_write(25'h33, 8'h00);
		expect_write(25'h34, 8'hA0);
		drain_writes();
		finish_test();

		start_test("cartridge header");
		begin_download(IDX_CRT_A);
		for (i = 0; i < 64; i++) begin
			send_byte(i, crt_header_byte(i), 1'b0, '0);
		end
		check_value("cart_info_o", 32'h0020_0100, cart_info_o);
		send_packet(int'(CRT_DATA_START), 16'h0000, CRT_BASE);
		drain_writes();
		check_value("bank records", 32'd1, bank_count);
		finish_test();

		// First data ends at CRT_BASE + 20h so the next bank starts 8 KB up
		start_test("second packet");
		send_packet(int'(CRT_DATA_START) + 48, 16'h0001, CRT_BASE + 25'h2000);
		drain_writes();
		end_download();
		check_value("bank records", 32'd2, bank_count);
		finish_test();

		start_test("tape and wait flag");
		slow_slots = 1'b1;
		wait_chk   = 1'b1;
		begin_download(IDX_TAP);
		for (i = 0; i < 40; i++) begin
			b = 8'($urandom);
			send_byte(i, b, 1'b1, TAP_BASE + mem_addr_t'(i));
		end
		end_download();
		drain_writes();
		wait_chk   = 1'b0;
		slow_slots = 1'b0;
		finish_test();

		$display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (timed_out || errors != 0 || tests_failed != 0) begin
			$display("Result: FAILED");
		end else begin
			$display("Result: PASSED");
		end
		$finish;
	end

endmodule

//--- flist.f
rtl/loader_pkg.sv
rtl/stream_decoder.sv
rtl/prg_tap_addresser.sv
rtl/crt_parser.sv
rtl/basic_ptr_init.sv
rtl/slot_writer.sv
rtl/c64_loader_top.sv
sim/tb_c64_loader.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_c64_loader
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
